//--- Bender.yml
package:
  name: commu

sources:
  # rtl in compile order
  - files:
      - logic/commu_pkg.sv
      - logic/commu_frame_assembler.sv
      - logic/commu_pkt_buffer.sv
      - logic/commu_host_irq.sv
      - logic/commu_top.sv

  # testbench
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_commu_top.sv

//--- logic/commu_frame_assembler.sv
// --------------------
// link_frm and link_byte_valid must be synchronous to clk_sys
// bytes past PKT_BYTES are dropped and flagged as oversize
// --------------------
`timescale 1ns/10ps
`default_nettype none

module commu_frame_assembler (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                link_frm,
	input  logic                link_byte_valid,
	input  logic [7:0]          link_byte,
	output logic                pkt_wr,
	output commu_pkg::commu_pkt_t pkt_in
);

	import commu_pkg::*;

	logic                   frm_q;
	logic                   frm_fall;
	logic                   byte_take;
	logic [LEN_W-1:0]       byte_cnt;
	logic                   ovs_q;
	logic [8*PKT_BYTES-1:0] data_q;

	// --------------------
	// frame edge
	// --------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			frm_q <= 1'b0;
		end else begin
			frm_q <= link_frm;
		end
	end

	assign frm_fall  = frm_q & ~link_frm;
	assign byte_take = link_frm & link_byte_valid;

	// --------------------
	// byte collection
	// --------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			byte_cnt <= '0;
			ovs_q    <= 1'b0;
			data_q   <= '0;
		end else if (frm_fall) begin
			// frame closed, start clean for the next one
			byte_cnt <= '0;
			ovs_q    <= 1'b0;
			data_q   <= '0;
		end else if (byte_take) begin
			if (byte_cnt < PKT_BYTES) begin
				data_q[8*byte_cnt +: 8] <= link_byte;
				byte_cnt                <= byte_cnt + 1'b1;
			end else begin
				ovs_q <= 1'b1;
			end
		end
	end

	// --------------------
	// packet out
	// --------------------

	// empty frames produce no write
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pkt_wr <= 1'b0;
		end else begin
			pkt_wr <= frm_fall && (byte_cnt != '0);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (frm_fall) begin
			pkt_in <= '{data: data_q, len: byte_cnt, oversize: ovs_q};
		end
	end

endmodule

`default_nettype wire

//--- logic/commu_host_irq.sv
// --------------------
// host_ack is asynchronous, the host lowers it before the next interrupt
// a missed ack costs the head packet after WD_LIMIT cycles
// --------------------
`timescale 1ns/10ps
`default_nettype none

module commu_host_irq (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        host_ack,
	input  logic [commu_pkg::CNT_W-1:0] pkt_count,
	output logic                        pop_ack,
	output logic                        pop_flush,
	output logic                        irq_n,
	output logic                        host_rdy
);

	import commu_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE = 3'h0,
		S_UP   = 3'h2,
		S_DOWN = 3'h3,
		S_RST  = 3'h6,
		S_DONE = 3'h7
	} irq_state_t;

	irq_state_t                          state;
	logic [$clog2(POR_HOLD+1)-1:0]       por_cnt;
	logic [$clog2(WD_LIMIT+1)-1:0]       wd_cnt;
	logic [$clog2(DOWN_HOLD+1)-1:0]      down_cnt;
	logic                                por_done;
	logic                                wd_expire;
	logic                                down_done;
	logic                                ack_s1;
	logic                                ack_s2;
	logic                                ack_s3;
	logic                                ack_rise;
	logic                                irq_q;

	// --------------------
	// power-on hold
	// --------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			por_cnt <= '0;
		end else if (!por_done) begin
			por_cnt <= por_cnt + 1'b1;
		end
	end

	assign por_done = (por_cnt == POR_HOLD);

	// --------------------
	// ack synchronizer
	// --------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ack_s1 <= 1'b0;
			ack_s2 <= 1'b0;
			ack_s3 <= 1'b0;
		end else begin
			ack_s1 <= host_ack;
			ack_s2 <= ack_s1;
			ack_s3 <= ack_s2;
		end
	end

	assign ack_rise = ack_s2 & ~ack_s3;

	// --------------------
	// interrupt fsm
	// --------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_RST;
		end else begin
			unique case (state)
				S_RST:   state <= por_done ? S_IDLE : S_RST;
				S_IDLE:  state <= (pkt_count != '0) ? S_UP : S_IDLE;
				S_UP:    state <= (ack_rise || wd_expire) ? S_DOWN : S_UP;
				S_DOWN:  state <= down_done ? S_DONE : S_DOWN;
				S_DONE:  state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// ack wins if both land in the same cycle
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pop_ack   <= 1'b0;
			pop_flush <= 1'b0;
			irq_q     <= 1'b0;
		end else begin
			pop_ack   <= (state == S_UP) && ack_rise;
			pop_flush <= (state == S_UP) && wd_expire && !ack_rise;
			irq_q     <= (state == S_UP);
		end
	end

	// hold time after a pop
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			down_cnt <= '0;
		end else if (state == S_DOWN) begin
			down_cnt <= down_cnt + 1'b1;
		end else begin
			down_cnt <= '0;
		end
	end

	assign down_done = (down_cnt == DOWN_HOLD - 1);

	// watchdog runs only while the interrupt is asserted
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wd_cnt <= '0;
		end else if (irq_q) begin
			wd_cnt <= wd_cnt + 1'b1;
		end else begin
			wd_cnt <= '0;
		end
	end

	assign wd_expire = (wd_cnt == WD_LIMIT - 1);

	assign irq_n    = ~irq_q;
	assign host_rdy = irq_q;

	// --------------------
	// checks
	// --------------------

	a_por_quiet: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!por_done |-> irq_n
	) else $error("irq_n asserted during power-on hold");

	a_ack_pulse: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		pop_ack |=> !pop_ack
	) else $error("pop_ack longer than one cycle");

	a_flush_pulse: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		pop_flush |=> !pop_flush
	) else $error("pop_flush longer than one cycle");

endmodule

`default_nettype wire

//--- logic/commu_pkg.sv
// --------------------
// timing constants are in clk_sys cycles and scaled for simulation
// depth and packet size are fixed at elaboration
// --------------------
`default_nettype none

package commu_pkg;

	// --------------------
	// packet geometry
	// --------------------

	// most payload bytes kept from one frame
	localparam int PKT_BYTES = 4;

	// bits needed for a byte count of 0 to PKT_BYTES
	localparam int LEN_W = $clog2(PKT_BYTES + 1);

	// fifo depth in packets
	localparam int PKT_DEPTH = 8;

	// occupancy width, holds 0 to PKT_DEPTH
	localparam int CNT_W = 4;

	// fifo pointer width
	localparam int PTR_W = $clog2(PKT_DEPTH);

	// --------------------
	// host interrupt timing
	// --------------------

	// interrupt held inactive this long after reset release
	localparam int POR_HOLD = 64;

	// cycles of low irq_n without ack before the head is flushed
	localparam int WD_LIMIT = 300;

	// irq_n high time after an ack or a flush
	localparam int DOWN_HOLD = 8;

	// one buffered packet, first link byte in data[7:0]
	typedef struct packed {
		logic [8*PKT_BYTES-1:0] data;
		logic [LEN_W-1:0]       len;
		logic                   oversize;
	} commu_pkt_t;

	// counters seen by the host side
	typedef struct packed {
		logic [CNT_W-1:0] count;
		logic [7:0]       ovf_cnt;
		logic [7:0]       flush_cnt;
	} commu_status_t;

endpackage

`default_nettype wire

//--- logic/commu_pkt_buffer.sv
// --------------------
// a write into a full buffer is dropped and counted, never stalled
// head_pkt is only meaningful while pkt_count is nonzero
// --------------------
`timescale 1ns/10ps
`default_nettype none

module commu_pkt_buffer (
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  logic                           pkt_wr,
	input  commu_pkg::commu_pkt_t          pkt_in,
	input  logic                           pop_ack,
	input  logic                           pop_flush,
	output logic [commu_pkg::CNT_W-1:0]    pkt_count,
	output commu_pkg::commu_pkt_t          head_pkt,
	output commu_pkg::commu_status_t       status
);

	import commu_pkg::*;

	commu_pkt_t       mem [PKT_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count_q;
	logic [7:0]       ovf_cnt;
	logic [7:0]       flush_cnt;
	logic             empty;
	logic             full;
	logic             do_wr;
	logic             do_pop;

	assign empty  = (count_q == '0);
	assign full   = (count_q == CNT_W'(PKT_DEPTH));
	assign do_wr  = pkt_wr & ~full;
	assign do_pop = (pop_ack | pop_flush) & ~empty;

	// --------------------
	// storage
	// --------------------

	always_ff @(posedge clk_sys) begin
		if (do_wr) begin
			mem[wr_ptr] <= pkt_in;
		end
	end

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_q <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			unique case ({do_wr, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// --------------------
	// drop and flush counters
	// --------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ovf_cnt   <= '0;
			flush_cnt <= '0;
		end else begin
			if (pkt_wr && full && ovf_cnt != 8'hff) begin
				ovf_cnt <= ovf_cnt + 1'b1;
			end
			if (pop_flush && !empty && flush_cnt != 8'hff) begin
				flush_cnt <= flush_cnt + 1'b1;
			end
		end
	end

	assign pkt_count = count_q;
	assign head_pkt  = mem[rd_ptr];
	assign status    = '{count: count_q, ovf_cnt: ovf_cnt, flush_cnt: flush_cnt};

	// --------------------
	// checks
	// --------------------

	// irq controller only pops while it sees packets
	a_no_pop_empty: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(pop_ack || pop_flush) |-> !empty
	) else $error("pop on empty buffer");

	a_one_pop_src: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!(pop_ack && pop_flush)
	) else $error("ack and flush pop together");

	a_count_range: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		count_q <= CNT_W'(PKT_DEPTH)
	) else $error("count above depth");

endmodule

`default_nettype wire

//--- logic/commu_top.sv
// --------------------
// link inputs are synchronous to clk_sys, host_ack may be asynchronous
// --------------------
`timescale 1ns/10ps
`default_nettype none

module commu_top (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     link_frm,
	input  logic                     link_byte_valid,
	input  logic [7:0]               link_byte,
	input  logic                     host_ack,
	output logic                     irq_n,
	output logic                     host_rdy,
	output commu_pkg::commu_pkt_t    rd_pkt,
	output commu_pkg::commu_status_t status
);

	import commu_pkg::*;

	logic             pkt_wr;
	commu_pkt_t       pkt_in;
	logic [CNT_W-1:0] pkt_count;
	logic             pop_ack;
	logic             pop_flush;

	// link side
	commu_frame_assembler frame_assembler_i (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.link_frm        (link_frm),
		.link_byte_valid (link_byte_valid),
		.link_byte       (link_byte),
		.pkt_wr          (pkt_wr),
		.pkt_in          (pkt_in)
	);

	// head packet goes straight out to the host
	commu_pkt_buffer pkt_buffer_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.pkt_wr    (pkt_wr),
		.pkt_in    (pkt_in),
		.pop_ack   (pop_ack),
		.pop_flush (pop_flush),
		.pkt_count (pkt_count),
		.head_pkt  (rd_pkt),
		.status    (status)
	);

	// host side
	commu_host_irq host_irq_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.host_ack  (host_ack),
		.pkt_count (pkt_count),
		.pop_ack   (pop_ack),
		.pop_flush (pop_flush),
		.irq_n     (irq_n),
		.host_rdy  (host_rdy)
	);

endmodule

`default_nettype wire

//--- tb.f
logic/commu_pkg.sv
logic/commu_frame_assembler.sv
logic/commu_pkt_buffer.sv
logic/commu_host_irq.sv
logic/commu_top.sv
test/tb_clk_gen.sv
test/tb_commu_top.sv

//--- test/tb_clk_gen.sv
// --------------------
// free-running 4 ns clock, reset low for the first 10 cycles
// --------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#2 clk_sys = ~clk_sys;
		end
	end

	// release on a clock edge, like a synchronized board reset
	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk_sys);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- test/tb_commu_top.sv
// --------------------
// frames run in groups; the host holds its acks until a group is sent
// a group must end well within WD_LIMIT cycles of its first packet
// --------------------
`timescale 1ns/10ps
`default_nettype none

module tb_commu_top;

	import commu_pkg::*;

	localparam int unsigned SEED = 32'h52ca881c;

	// one stimulus row with byte 0 of the frame in bytes[7:0]
	typedef struct packed {
		logic [2:0]  nbytes;
		logic [47:0] bytes;
		logic [15:0] idle;
		logic        ignore;
	} frame_t;

	logic          clk_sys;
	logic          rst_n;
	logic          link_frm;
	logic          link_byte_valid;
	logic [7:0]    link_byte;
	logic          host_ack;
	logic          irq_n;
	logic          host_rdy;
	commu_pkt_t    rd_pkt;
	commu_status_t status;

	frame_t        frames[$];
	string         names[$];
	int            test_err[$];
	commu_pkt_t    exp_pkt_q[$];
	int            exp_idx_q[$];
	int            exp_ovf;
	int            exp_flush;
	int            misc_err;
	int            rst_cycles;
	int            cycle_limit;
	int unsigned   seed_val;
	logic          host_hold;
	int            e;
	int            k;
	int            group_start;
	int            total_err;
	int            failed_tests;

	tb_clk_gen clk_gen_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	commu_top commu_top_i (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.link_frm        (link_frm),
		.link_byte_valid (link_byte_valid),
		.link_byte       (link_byte),
		.host_ack        (host_ack),
		.irq_n           (irq_n),
		.host_rdy        (host_rdy),
		.rd_pkt          (rd_pkt),
		.status          (status)
	);

	// --------------------
	// helpers
	// --------------------

	task automatic add_entry(input string name, input int n, input logic [47:0] bytes,
			input int idle, input logic ignore);
		frame_t f;
		f.nbytes = n[2:0];
		f.bytes  = bytes;
		f.idle   = idle[15:0];
		f.ignore = ignore;
		frames.push_back(f);
		names.push_back(name);
		test_err.push_back(0);
	endtask

	task automatic check_value(input int idx, input string what,
			input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s %s: expected 0x%0h, actual 0x%0h",
				names[idx], what, expected, actual);
			test_err[idx] = test_err[idx] + 1;
		end
	endtask

	// first four bytes kept, len capped and oversize set past four
	function automatic commu_pkt_t expect_pkt(input frame_t f);
		commu_pkt_t p;
		int i;
		p = '0;
		for (i = 0; i < f.nbytes && i < PKT_BYTES; i++) begin
			p.data[8*i +: 8] = f.bytes[8*i +: 8];
		end
		p.len      = (f.nbytes > PKT_BYTES) ? PKT_BYTES : f.nbytes;
		p.oversize = (f.nbytes > PKT_BYTES);
		return p;
	endfunction

	task automatic send_frame(input frame_t f);
		int gap;
		int i;
		@(posedge clk_sys);
		link_frm        <= 1'b1;
		link_byte_valid <= 1'b0;
		for (i = 0; i < f.nbytes; i++) begin
			gap = $urandom % 2;
			repeat (gap) begin
				@(posedge clk_sys);
				link_byte_valid <= 1'b0;
			end
			@(posedge clk_sys);
			link_byte_valid <= 1'b1;
			link_byte       <= f.bytes[8*i +: 8];
		end
		@(posedge clk_sys);
		link_byte_valid <= 1'b0;
		link_frm        <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic check_status(input int idx, input string when);
		check_value(idx, {"count ", when}, exp_pkt_q.size(), status.count);
		check_value(idx, {"ovf_cnt ", when}, exp_ovf, status.ovf_cnt);
		check_value(idx, {"flush_cnt ", when}, exp_flush, status.flush_cnt);
	endtask

	task automatic wait_irq_high();
		do begin
			@(posedge clk_sys);
		end while (irq_n !== 1'b1);
	endtask

	// buffer empty, nothing expected and the host back at rest
	task automatic drain();
		do begin
			@(posedge clk_sys);
		end while (!(status.count == 0 && irq_n === 1'b1 && exp_pkt_q.size() == 0
			&& host_ack === 1'b0));
		repeat (2) @(posedge clk_sys);
	endtask

	// --------------------
	// host model
	// --------------------

	task automatic serve_irq();
		int idx;
		if (exp_pkt_q.size() == 0) begin
			$display("ERROR interrupt raised while no packet was expected");
			misc_err = misc_err + 1;
			wait_irq_high();
		end else begin
			idx = exp_idx_q[0];
			check_value(idx, "irq_n fell during power-on hold", 1, rst_cycles >= POR_HOLD);
			check_value(idx, "host_rdy with irq_n low", 1, host_rdy);
			check_value(idx, "rd_pkt", exp_pkt_q[0], rd_pkt);
			if (frames[idx].ignore) begin
				// the watchdog must take the packet from a silent host
				wait_irq_high();
				exp_flush = exp_flush + 1;
			end else begin
				while (host_hold) @(posedge clk_sys);
				host_ack <= 1'b1;
				wait_irq_high();
				check_value(idx, "count after ack", exp_pkt_q.size() - 1, status.count);
				host_ack <= 1'b0;
			end
			void'(exp_pkt_q.pop_front());
			void'(exp_idx_q.pop_front());
		end
	endtask

	initial begin
		host_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			if (rst_n === 1'b1 && irq_n === 1'b0) begin
				serve_irq();
			end
		end
	end

	// --------------------
	// cycle count and timeout
	// --------------------

	initial begin
		rst_cycles = 0;
	end

	always @(posedge clk_sys) begin
		if (rst_n === 1'b1) begin
			rst_cycles <= rst_cycles + 1;
		end
	end

	initial begin
		wait (cycle_limit > 0);
		wait (rst_cycles >= cycle_limit);
		$display("timeout: the run did not finish within %0d cycles after reset", cycle_limit);
		$display("Result: FAILED");
		$finish;
	end

	// --------------------
	// stimulus table and main loop
	// --------------------

	initial begin
		link_frm        = 1'b0;
		link_byte_valid = 1'b0;
		link_byte       = 8'h00;
		host_hold       = 1'b0;
		exp_ovf         = 0;
		exp_flush       = 0;
		misc_err        = 0;
		cycle_limit     = 0;
		seed_val        = $urandom(SEED);

		// idle 0 chains a frame into the next one of the same group
		add_entry("por_frame", 2, 48'h2211, 6, 1'b0);
		add_entry("one_byte", 1, 48'ha5, 20, 1'b0);
		add_entry("two_bytes", 2, 48'h3c5a, 0, 1'b0);
		add_entry("three_bytes", 3, 48'h030201, 0, 1'b0);
		add_entry("four_bytes", 4, 48'hdeadbeef, 20, 1'b0);
		add_entry("six_bytes", 6, 48'h665544332211, 20, 1'b0);
		add_entry("zero_bytes", 0, 48'h0, 20, 1'b0);
		add_entry("ignored", 2, 48'h0b0a, 0, 1'b1);
		add_entry("after_flush", 3, 48'h0e0d0c, 20, 1'b0);
		for (k = 0; k < 10; k++) begin
			add_entry($sformatf("burst_%0d", k), 1, 48'hb0 + k, (k == 9) ? 10 : 0, 1'b0);
		end

		cycle_limit = POR_HOLD;
		foreach (frames[i]) begin
			cycle_limit += 2 * frames[i].nbytes + frames[i].idle + WD_LIMIT + DOWN_HOLD + 50;
		end

		wait (rst_n === 1'b1);
		@(posedge clk_sys);
		check_value(0, "irq_n after reset", 1, irq_n);
		check_value(0, "host_rdy after reset", 0, host_rdy);
		check_value(0, "status after reset", 0, status);

		group_start = 0;
		for (e = 0; e < frames.size(); e++) begin
			host_hold <= 1'b1;
			send_frame(frames[e]);
			if (frames[e].nbytes != 0) begin
				if (exp_pkt_q.size() < PKT_DEPTH) begin
					exp_pkt_q.push_back(expect_pkt(frames[e]));
					exp_idx_q.push_back(e);
				end else begin
					exp_ovf = exp_ovf + 1;
				end
			end
			if (frames[e].idle != 0) begin
				repeat (frames[e].idle) @(posedge clk_sys);
				check_status(e, "at group end");
				if (rst_cycles < POR_HOLD) begin
					check_value(e, "irq_n in power-on hold", 1, irq_n);
				end
				host_hold <= 1'b0;
				drain();
				check_status(e, "after drain");
				for (k = group_start; k <= e; k++) begin
					if (test_err[k] == 0) begin
						$display("test %-12s ok", names[k]);
					end else begin
						$display("test %-12s %0d errors", names[k], test_err[k]);
					end
				end
				group_start = e + 1;
			end
		end

		total_err    = misc_err;
		failed_tests = 0;
		foreach (test_err[i]) begin
			total_err += test_err[i];
			if (test_err[i] != 0) begin
				failed_tests++;
			end
		end
		$display("tests run %0d, tests failed %0d, errors %0d",
			frames.size(), failed_tests, total_err);
		if (total_err == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
